//--- run_sim.sh
#!/usr/bin/env bash
# build the decode testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decode_tb -f sources.f \
	&& ./obj_dir/Vdecode_tb | tee /dev/stderr | grep -qx "TB PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- source/decode_pipe_top.sv
`timescale 1ns/1ns
`default_nettype none

// two stage decode slice
// word in with in_valid, decoded bundle out two cycles later
module decode_pipe_top (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input rv_decode_pkg::inst_u inst,
	output logic out_valid,
	output rv_decode_pkg::decoded_t decoded
);

	// between the stages
	logic pre_valid;
	rv_decode_pkg::predecode_t pre;

	// opcode class flags registered with the word
	inst_predecode u_predecode (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.inst(inst),
		.pre_valid(pre_valid),
		.pre(pre)
	);

	// fields, immediate and op selects
	inst_field_decode u_field_decode (
		.clk(clk),
		.arst_n(arst_n),
		.pre_valid(pre_valid),
		.pre(pre),
		.out_valid(out_valid),
		.decoded(decoded)
	);

endmodule

`default_nettype wire

//--- source/inst_field_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_decode_config.svh"

// stage two
// register indices, immediate and op selects from the predecoded word
module inst_field_decode (
	input logic clk,
	input logic arst_n,
	input logic pre_valid,
	input rv_decode_pkg::predecode_t pre,
	output logic out_valid,
	output rv_decode_pkg::decoded_t decoded
);

	logic [`INST_WIDTH-1:0] inst_word;
	logic sign;
	logic type_lui, type_auipc, type_load, type_store, type_op_imm, type_op;
	logic i_type, u_type, j_type, b_type, s_type, r_type;
	logic rs1_sel, rs2_sel, rd_wen;
	logic [`DATA_WIDTH-1:0] imm_i, imm_u, imm_j, imm_b, imm_s, imm_sys;
	rv_decode_pkg::alu_op_e alu_opt;
	rv_decode_pkg::src_sel_e src_sel;
	rv_decode_pkg::lsu_op_e lsu_opt;
	rv_decode_pkg::decoded_t dec_next;

	assign inst_word = pre.inst;
	// instruction msb is the sign of every immediate
	assign sign = inst_word[`INST_WIDTH-1];

	// jal, jalr, branch and sys already come from stage one
	assign type_lui = (pre.inst.r.opcode == rv_decode_pkg::OPC_LUI);
	assign type_auipc = (pre.inst.r.opcode == rv_decode_pkg::OPC_AUIPC);
	assign type_load = (pre.inst.r.opcode == rv_decode_pkg::OPC_LOAD);
	assign type_store = (pre.inst.r.opcode == rv_decode_pkg::OPC_STORE);
	assign type_op_imm = (pre.inst.r.opcode == rv_decode_pkg::OPC_OP_IMM);
	assign type_op = (pre.inst.r.opcode == rv_decode_pkg::OPC_OP);

	// format class
	assign i_type = pre.jalr | type_load | type_op_imm | pre.sys;
	assign u_type = type_lui | type_auipc;
	assign j_type = pre.jal;
	assign b_type = pre.branch;
	assign s_type = type_store;
	assign r_type = type_op;

	// which register fields are real for this format
	assign rs1_sel = i_type | b_type | s_type | r_type;
	assign rs2_sel = b_type | s_type | r_type;
	assign rd_wen = u_type | j_type | i_type | r_type;

	// candidate immediates, each sign extended from bit 31
	assign imm_i = {{(`DATA_WIDTH-12){sign}}, pre.inst.i.imm_11_0};
	assign imm_u = {pre.inst.u.imm_31_12, 12'd0};
	assign imm_j = {{(`DATA_WIDTH-21){sign}}, pre.inst.j.imm_20, pre.inst.j.imm_19_12,
		pre.inst.j.imm_11, pre.inst.j.imm_10_1, 1'b0};
	assign imm_b = {{(`DATA_WIDTH-13){sign}}, pre.inst.b.imm_12, pre.inst.b.imm_11,
		pre.inst.b.imm_10_5, pre.inst.b.imm_4_1, 1'b0};
	assign imm_s = {{(`DATA_WIDTH-12){sign}}, pre.inst.s.imm_11_5, pre.inst.s.imm_4_0};
	// csr number and zimm travel together as bits 31..15
	assign imm_sys = {{(`DATA_WIDTH-17){sign}}, pre.inst.i.imm_11_0, pre.inst.i.rs1};

	op_select_decode u_op_select (
		.opcode(pre.inst.r.opcode),
		.funct3(pre.inst.r.funct3),
		.funct7(pre.inst.r.funct7[5]),
		.alu_opt(alu_opt),
		.src_sel(src_sel),
		.lsu_opt(lsu_opt)
	);

	always_comb begin
		dec_next.rd = rd_wen ? pre.inst.r.rd : '0;
		dec_next.rd_wen = rd_wen;
		dec_next.rs1 = rs1_sel ? pre.inst.r.rs1 : '0;
		dec_next.rs2 = rs2_sel ? pre.inst.r.rs2 : '0;
		// formats are exclusive, order only matters for sys inside i
		if (pre.sys) begin
			dec_next.imm = imm_sys;
		end else if (i_type) begin
			dec_next.imm = imm_i;
		end else if (u_type) begin
			dec_next.imm = imm_u;
		end else if (j_type) begin
			dec_next.imm = imm_j;
		end else if (b_type) begin
			dec_next.imm = imm_b;
		end else if (s_type) begin
			dec_next.imm = imm_s;
		end else begin
			// op, fence and unknown opcodes carry no immediate
			dec_next.imm = '0;
		end
		dec_next.alu_opt = alu_opt;
		dec_next.src_sel = src_sel;
		dec_next.lsu_opt = lsu_opt;
		dec_next.funct3 = pre.inst.r.funct3;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= pre_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (pre_valid) begin
			decoded <= dec_next;
		end
	end

endmodule

`default_nettype wire

//--- source/inst_predecode.sv
`timescale 1ns/1ns
`default_nettype none

// stage one
// spots control-transfer and system opcodes early so stage two
// only has to look at the remaining major opcodes
module inst_predecode (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input rv_decode_pkg::inst_u inst,
	output logic pre_valid,
	output rv_decode_pkg::predecode_t pre
);

	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic is_sys;

	// opcode sits at the same place in every format, r view is enough
	assign is_jal = (inst.r.opcode == rv_decode_pkg::OPC_JAL);
	assign is_jalr = (inst.r.opcode == rv_decode_pkg::OPC_JALR);
	assign is_branch = (inst.r.opcode == rv_decode_pkg::OPC_BRANCH);
	assign is_sys = (inst.r.opcode == rv_decode_pkg::OPC_SYSTEM);

	// valid follows in_valid one cycle later, no stall
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pre_valid <= 1'b0;
		end else begin
			pre_valid <= in_valid;
		end
	end

	// payload only moves with a valid word
	always_ff @(posedge clk) begin
		if (in_valid) begin
			pre.inst <= inst;
			pre.jal <= is_jal;
			pre.jalr <= is_jalr;
			pre.branch <= is_branch;
			pre.sys <= is_sys;
		end
	end

endmodule

`default_nettype wire

//--- source/op_select_decode.sv
`timescale 1ns/1ns
`default_nettype none

// purely combinational
// opcode, funct3 and inst[30] to ALU op, operand select and lsu class
module op_select_decode (
	input rv_decode_pkg::opcode_e opcode,
	input logic [2:0] funct3,
	input logic funct7,
	output rv_decode_pkg::alu_op_e alu_opt,
	output rv_decode_pkg::src_sel_e src_sel,
	output rv_decode_pkg::lsu_op_e lsu_opt
);

	// shared by op and op_imm, only funct3 000 differs
	rv_decode_pkg::alu_op_e reg_alu;

	always_comb begin
		case (funct3)
			3'b000: reg_alu = funct7 ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
			3'b001: reg_alu = rv_decode_pkg::ALU_SLL;
			3'b010: reg_alu = rv_decode_pkg::ALU_SLT;
			3'b011: reg_alu = rv_decode_pkg::ALU_SLTU;
			3'b100: reg_alu = rv_decode_pkg::ALU_XOR;
			// funct7 bit picks arithmetic shift
			3'b101: reg_alu = funct7 ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
			3'b110: reg_alu = rv_decode_pkg::ALU_OR;
			default: reg_alu = rv_decode_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		alu_opt = rv_decode_pkg::ALU_NONE;
		src_sel = rv_decode_pkg::SRC_RS1_IMM;
		lsu_opt = rv_decode_pkg::LSU_NONE;
		case (opcode)
			rv_decode_pkg::OPC_OP: begin
				alu_opt = reg_alu;
				src_sel = rv_decode_pkg::SRC_RS1_RS2;
			end
			rv_decode_pkg::OPC_OP_IMM: begin
				// addi has no subtract form, inst[30] is immediate there
				alu_opt = (funct3 == 3'b000) ? rv_decode_pkg::ALU_ADD : reg_alu;
			end
			rv_decode_pkg::OPC_BRANCH: begin
				src_sel = rv_decode_pkg::SRC_RS1_RS2;
				// beq/bne compare via subtract, signed and unsigned via slt
				case (funct3)
					3'b000, 3'b001: alu_opt = rv_decode_pkg::ALU_SUB;
					3'b100, 3'b101: alu_opt = rv_decode_pkg::ALU_SLT;
					3'b110, 3'b111: alu_opt = rv_decode_pkg::ALU_SLTU;
					default: alu_opt = rv_decode_pkg::ALU_NONE;
				endcase
			end
			rv_decode_pkg::OPC_LUI: begin
				alu_opt = rv_decode_pkg::ALU_ADD;
			end
			rv_decode_pkg::OPC_AUIPC: begin
				alu_opt = rv_decode_pkg::ALU_ADD;
				src_sel = rv_decode_pkg::SRC_PC_IMM;
			end
			rv_decode_pkg::OPC_JAL, rv_decode_pkg::OPC_JALR: begin
				// link value is pc + 4
				alu_opt = rv_decode_pkg::ALU_ADD;
				src_sel = rv_decode_pkg::SRC_PC_4;
			end
			rv_decode_pkg::OPC_LOAD: lsu_opt = rv_decode_pkg::LSU_LOAD;
			rv_decode_pkg::OPC_STORE: lsu_opt = rv_decode_pkg::LSU_STORE;
			rv_decode_pkg::OPC_SYSTEM: lsu_opt = rv_decode_pkg::LSU_SYS;
			default: begin
				// fence and unknown words keep the defaults above
				alu_opt = rv_decode_pkg::ALU_NONE;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// widths shared by the decode pipeline

// raw instruction word
`define INST_WIDTH 32

// immediate and datapath word
`define DATA_WIDTH 32

// architectural register index, x0..x31
`define REG_WIDTH 5

// ALU operation code, eleven ops fit in four bits
`define ALU_OPT_WIDTH 4

// operand source select
// rs1/imm, pc/imm, pc/4, rs1/rs2
`define SRC_SEL_WIDTH 2

// load/store class
// none, load, store, system
`define LSU_OPT_WIDTH 2

`endif

//--- source/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_config.svh"

package rv_decode_pkg;

	// major opcodes of RV32I, low two bits always 11
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b01101_11,
		OPC_AUIPC  = 7'b00101_11,
		OPC_JAL    = 7'b11011_11,
		OPC_JALR   = 7'b11001_11,
		OPC_BRANCH = 7'b11000_11,
		OPC_LOAD   = 7'b00000_11,
		OPC_STORE  = 7'b01000_11,
		OPC_OP_IMM = 7'b00100_11,
		OPC_OP     = 7'b01100_11,
		OPC_FENCE  = 7'b00011_11,
		OPC_SYSTEM = 7'b11100_11
	} opcode_e;

	typedef enum logic [`ALU_OPT_WIDTH-1:0] {
		ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	// zero encodes rs1/imm, the default for unlisted opcodes
	typedef enum logic [`SRC_SEL_WIDTH-1:0] {
		SRC_RS1_IMM = 2'd0,
		SRC_PC_IMM  = 2'd1,
		SRC_PC_4    = 2'd2,
		SRC_RS1_RS2 = 2'd3
	} src_sel_e;

	typedef enum logic [`LSU_OPT_WIDTH-1:0] {
		LSU_NONE, LSU_LOAD, LSU_STORE, LSU_SYS
	} lsu_op_e;

	// the six instruction formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [`REG_WIDTH-1:0] rs2;
		logic [`REG_WIDTH-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_WIDTH-1:0] rd;
		opcode_e opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [`REG_WIDTH-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_WIDTH-1:0] rd;
		opcode_e opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [`REG_WIDTH-1:0] rs2;
		logic [`REG_WIDTH-1:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		opcode_e opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [`REG_WIDTH-1:0] rs2;
		logic [`REG_WIDTH-1:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		opcode_e opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [`REG_WIDTH-1:0] rd;
		opcode_e opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [`REG_WIDTH-1:0] rd;
		opcode_e opcode;
	} j_fmt_t;

	// one instruction word, readable in any format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

	// stage one register, word plus early opcode class
	typedef struct packed {
		inst_u inst;
		logic jal;
		logic jalr;
		logic branch;
		logic sys;
	} predecode_t;

	// stage two result handed to execute
	typedef struct packed {
		logic [`REG_WIDTH-1:0] rd;
		logic rd_wen;
		logic [`REG_WIDTH-1:0] rs1;
		logic [`REG_WIDTH-1:0] rs2;
		logic [`DATA_WIDTH-1:0] imm;
		alu_op_e alu_opt;
		src_sel_e src_sel;
		lsu_op_e lsu_opt;
		logic [2:0] funct3;
	} decoded_t;

endpackage

`default_nettype wire

//--- sources.f
+incdir+source
source/rv_decode_pkg.sv
source/op_select_decode.sv
source/inst_predecode.sv
source/inst_field_decode.sv
source/decode_pipe_top.sv
verif/decode_properties.sv
verif/decode_tb.sv

//--- verif/decode_patterns.hex
// inst rd rd_wen rs1 rs2 imm alu_opt src_sel lsu_opt funct3
// alu 0 none 1 add 2 sub 3 sll 4 slt 5 sltu 6 xor 7 srl 8 sra 9 or a and / lsu 1 ld 2 st 3 sys
003100B3 01 1 02 03 00000000 1 3 0 0
407302B3 05 1 06 07 00000000 2 3 0 0
00A49433 08 1 09 0A 00000000 3 3 0 1
00D625B3 0B 1 0C 0D 00000000 4 3 0 2
0107B733 0E 1 0F 10 00000000 5 3 0 3
013948B3 11 1 12 13 00000000 6 3 0 4
016ADA33 14 1 15 16 00000000 7 3 0 5
419C5BB3 17 1 18 19 00000000 8 3 0 5
01CDED33 1A 1 1B 1C 00000000 9 3 0 6
01FF7EB3 1D 1 1E 1F 00000000 A 3 0 7
FFF10093 01 1 02 00 FFFFFFFF 1 0 0 0
00521193 03 1 04 00 00000005 3 0 0 1
7FF32293 05 1 06 00 000007FF 4 0 0 2
80043393 07 1 08 00 FFFFF800 5 0 0 3
12354493 09 1 0A 00 00000123 6 0 0 4
40765593 0B 1 0C 00 00000407 8 0 0 5
00375693 0D 1 0E 00 00000003 7 0 0 5
0010E093 01 1 01 00 00000001 9 0 0 6
FF087793 0F 1 10 00 FFFFFFF0 A 0 0 7
00208463 00 0 01 02 00000008 2 3 0 0
FE41CEE3 00 0 03 04 FFFFFFFC 4 3 0 4
0062F0E3 00 0 05 06 00000800 5 3 0 7
00742A23 00 0 08 07 00000014 0 0 2 2
FE950EA3 00 0 0A 09 FFFFFFFD 0 0 2 0
FF862583 0B 1 0C 00 FFFFFFF8 0 0 1 2
123452B7 05 1 00 00 12345000 1 0 0 5
FFFFF317 06 1 00 00 FFFFF000 1 1 0 7
001000EF 01 1 00 00 00000800 1 2 0 0
FFDFF16F 02 1 00 00 FFFFFFFC 1 2 0 7
00C280E7 01 1 05 00 0000000C 1 2 0 0
305211F3 03 1 04 00 000060A4 0 0 3 1
C003E2F3 05 1 07 00 FFFF8007 0 0 3 6
00000073 00 1 00 00 00000000 0 0 3 0
0FF0000F 00 0 00 00 00000000 0 0 0 0
FFFFFFFF 00 0 00 00 00000000 0 0 0 7

//--- verif/decode_properties.sv
`timescale 1ns/1ns
`default_nettype none

// port checks on the decode top
module decode_properties (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic out_valid,
	input rv_decode_pkg::decoded_t decoded
);

	// two register stages and no stall
	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == $past(in_valid, 2))
		else $error("out_valid is not in_valid delayed by two cycles");

	assert property (@(posedge clk) !arst_n |-> !out_valid)
		else $error("out_valid high during reset");

	// no write means no destination
	assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && !decoded.rd_wen) |-> (decoded.rd == '0))
		else $error("rd nonzero with rd_wen low");

	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> !$isunknown(decoded))
		else $error("decoded bundle has unknown bits");

endmodule

bind decode_pipe_top decode_properties u_properties (
	.clk(clk),
	.arst_n(arst_n),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.decoded(decoded)
);

`default_nettype wire

//--- verif/decode_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_decode_config.svh"

// plays the pattern file through the decode pipe
// expected bundles come from the file and are matched in order
module decode_tb;

	// columns on one line of the pattern file
	localparam int FIELDS = 10;
	localparam int NUM_TESTS = 35;
	// at most one bubble per word plus drain and reset
	localparam int CYCLE_LIMIT = 3 * NUM_TESTS + 20;

	logic clk;
	logic arst_n;
	logic in_valid;
	rv_decode_pkg::inst_u inst;
	logic out_valid;
	rv_decode_pkg::decoded_t decoded;

	logic [31:0] pattern_mem [0:NUM_TESTS*FIELDS-1];
	rv_decode_pkg::decoded_t expect_q[$];
	int index_q[$];
	// in_valid driven on the last two falling edges with the newest in bit 0
	logic [1:0] valid_hist;
	int cycle_count;

	decode_pipe_top DUT (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.inst(inst),
		.out_valid(out_valid),
		.decoded(decoded)
	);

	// 20 ns period
	always #10 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("TB FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_decoded(input string name, input rv_decode_pkg::decoded_t expected,
		input rv_decode_pkg::decoded_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			abort_run("decoded bundle mismatch");
		end
	endtask

	task automatic check_valid(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %b actual %b", name, expected, actual);
			abort_run("out_valid mismatch");
		end
	endtask

	// rebuild the expected bundle from the columns of one pattern
	function automatic rv_decode_pkg::decoded_t pattern_expect(input int t);
		int base;
		rv_decode_pkg::decoded_t d;
		base = t * FIELDS;
		d.rd = pattern_mem[base + 1][`REG_WIDTH-1:0];
		d.rd_wen = pattern_mem[base + 2][0];
		d.rs1 = pattern_mem[base + 3][`REG_WIDTH-1:0];
		d.rs2 = pattern_mem[base + 4][`REG_WIDTH-1:0];
		d.imm = pattern_mem[base + 5];
		d.alu_opt = rv_decode_pkg::alu_op_e'(pattern_mem[base + 6][`ALU_OPT_WIDTH-1:0]);
		d.src_sel = rv_decode_pkg::src_sel_e'(pattern_mem[base + 7][`SRC_SEL_WIDTH-1:0]);
		d.lsu_opt = rv_decode_pkg::lsu_op_e'(pattern_mem[base + 8][`LSU_OPT_WIDTH-1:0]);
		d.funct3 = pattern_mem[base + 9][2:0];
		return d;
	endfunction

	// outputs settled at the last rising edge
	task automatic sample_outputs();
		rv_decode_pkg::decoded_t expected;
		int idx;
		check_valid($sformatf("out_valid at cycle %0d", cycle_count), valid_hist[1], out_valid);
		if (out_valid) begin
			expected = expect_q.pop_front();
			idx = index_q.pop_front();
			check_decoded($sformatf("pattern %0d inst %h", idx, pattern_mem[idx*FIELDS]),
				expected, decoded);
		end
	endtask

	// one falling edge
	// check what came out then drive the next input
	task automatic step_cycle(input logic valid, input int idx);
		@(negedge clk);
		sample_outputs();
		in_valid = valid;
		if (valid) begin
			inst = pattern_mem[idx*FIELDS];
			expect_q.push_back(pattern_expect(idx));
			index_q.push_back(idx);
		end
		valid_hist = {valid_hist[0], valid};
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("decoded output never arrived");
			abort_run("timeout");
		end
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		in_valid = 1'b0;
		inst = '0;
		valid_hist = '0;
		cycle_count = 0;
		void'($urandom(5943));
		$readmemh("verif/decode_patterns.hex", pattern_mem);
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) begin
			// idle cycle ahead of the word about half the time
			if ($urandom_range(1, 0) != 0) begin
				step_cycle(1'b0, 0);
			end
			step_cycle(1'b1, t);
		end
		// drain both stages
		while (expect_q.size() != 0) begin
			step_cycle(1'b0, 0);
		end
		// out_valid has to drop once the pipe is empty
		repeat (2) step_cycle(1'b0, 0);
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire
